// File: design/norm_pkg.sv
`default_nettype none

package norm_pkg;

    ////////////////////////////////////////////////////////////
    // fp16 word layout
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic       sign;
        logic [4:0] exp;
        logic [9:0] mant;
    } fp16_fields_t;

    // Registers and ports see raw bits, arithmetic sees fields
    typedef union packed {
        logic [15:0]  raw;
        fp16_fields_t fields;
    } fp16_u;

    // Special values
    localparam logic [15:0] FP16_MAX        = 16'h7BFF;
    localparam logic [15:0] FP16_ONE        = 16'h3C00;
    localparam logic [15:0] FP16_SIM_THRESH = 16'h3BD7;  // 0.98

    ////////////////////////////////////////////////////////////
    // Stage encoding
    ////////////////////////////////////////////////////////////

    localparam int STAGE_W = 3;

    localparam logic [STAGE_W-1:0] STAGE_SQRT   = 3'd4;
    localparam logic [STAGE_W-1:0] STAGE_COS    = 3'd5;
    localparam logic [STAGE_W-1:0] STAGE_ASSIGN = 3'd6;
    localparam logic [STAGE_W-1:0] STAGE_DONE   = 3'd7;

endpackage

`default_nettype wire

// File: design/stage_ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

interface stage_ctrl_if;
    import norm_pkg::*;

    logic [STAGE_W-1:0] stage;
    logic               advance;      // High when not stalled
    logic               stage_start;  // First cycle of a new stage
    logic               done;

    // Sequencer side
    modport seq (
        output stage,
        output advance,
        output stage_start,
        output done
    );

    // Lane side
    modport lane (
        input stage,
        input advance,
        input stage_start,
        input done
    );

endinterface

`default_nettype wire

// File: design/stage_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module stage_sequencer #(
    parameter int STEP_W = 16
) (
    input  logic                         CLK_i,
    input  logic                         RST_i,
    input  logic                         stall_i,
    input  logic [6:0][STEP_W-1:0]       boundary_i,
    stage_ctrl_if.seq                    ctrl,
    output logic                         mode_o,
    output logic                         finished_o,
    output logic [norm_pkg::STAGE_W-1:0] stage_o
);
    import norm_pkg::*;

    logic [STEP_W-1:0]  step;
    logic [STAGE_W-1:0] stage;
    logic [STAGE_W-1:0] stage_next;
    logic               start_q;
    logic               done;

    ////////////////////////////////////////////////////////////
    // Boundary decode
    ////////////////////////////////////////////////////////////

    // Highest boundary passed wins
    always_comb begin
        stage_next = '0;
        for (int i = 0; i < 7; i++) begin
            if (step > boundary_i[i]) begin
                stage_next = STAGE_W'(i + 1);
            end
        end
    end

    assign done = (stage == STAGE_DONE);

    // Step and stage freeze once the last stage is reached
    always_ff @(posedge CLK_i) begin
        if (RST_i) begin
            step    <= '0;
            stage   <= '0;
            start_q <= 1'b0;
        end else if (!stall_i) begin
            start_q <= !done && (stage_next != stage);
            if (!done) begin
                step  <= step + 1'b1;
                stage <= stage_next;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Outputs
    ////////////////////////////////////////////////////////////

    // Reconfigurable tile mode per stage
    always_comb begin
        case (stage)
            3'd0:    mode_o = 1'b1;
            3'd1:    mode_o = 1'b0;
            3'd2:    mode_o = 1'b1;
            3'd3:    mode_o = 1'b1;
            default: mode_o = 1'b1;
        endcase
    end

    // Pulse waits out a stall so the lanes still see it once
    assign ctrl.stage       = stage;
    assign ctrl.advance     = !stall_i;
    assign ctrl.stage_start = start_q && !stall_i;
    assign ctrl.done        = done;

    assign finished_o = done;
    assign stage_o    = stage;

endmodule

`default_nettype wire

// File: design/fp16_recip_rom.sv
`timescale 1ns/1ps
`default_nettype none

module fp16_recip_rom (
    input  norm_pkg::fp16_u value_i,
    output norm_pkg::fp16_u recip_o
);
    import norm_pkg::*;

    // Mantissa of 1/(1 + k/64), entry 0 unused
    function automatic logic [63:0][9:0] build_table();
        logic [63:0][9:0] tbl;
        tbl = '0;
        for (int k = 1; k < 64; k++) begin
            tbl[k] = 10'((131072 / (64 + k)) - 1024);
        end
        return tbl;
    endfunction

    localparam logic [63:0][9:0] RECIP_MANT = build_table();

    logic [4:0] e;
    logic [5:0] k;
    logic [5:0] exp_calc;
    fp16_u      res;

    assign e = value_i.fields.exp;
    assign k = value_i.fields.mant[9:4];

    // Exact powers of two keep one more exponent step
    assign exp_calc = ((k == 6'd0) ? 6'd30 : 6'd29) - {1'b0, e};

    always_comb begin
        res.raw         = '0;
        res.fields.sign = value_i.fields.sign;
        if (e == 5'd0) begin
            res.raw = {value_i.fields.sign, FP16_MAX[14:0]};
        end else if (e >= 5'd30 || exp_calc == 6'd0) begin
            res.fields.exp  = '0;  // Too large, result flushes
            res.fields.mant = '0;
        end else begin
            res.fields.exp  = exp_calc[4:0];
            res.fields.mant = RECIP_MANT[k];
        end
    end

    assign recip_o = res;

endmodule

`default_nettype wire

// File: design/fp16_sqrt_rom.sv
`timescale 1ns/1ps
`default_nettype none

module fp16_sqrt_rom (
    input  norm_pkg::fp16_u value_i,
    output norm_pkg::fp16_u root_o
);
    import norm_pkg::*;

    // Largest s with s*s <= radicand
    function automatic logic [10:0] isqrt(input int unsigned radicand);
        int unsigned lo;
        int unsigned hi;
        int unsigned mid;
        lo = 0;
        hi = 2048;
        for (int i = 0; i < 12; i++) begin
            mid = (lo + hi) / 2;
            if (mid * mid <= radicand) begin
                lo = mid;
            end else begin
                hi = mid;
            end
        end
        return 11'(lo);
    endfunction

    // Odd table covers the extra factor of two from an odd unbiased exponent
    function automatic logic [63:0][9:0] build_table(input logic odd);
        logic [63:0][9:0] tbl;
        int unsigned      radicand;
        for (int k = 0; k < 64; k++) begin
            radicand = 16384 * (64 + k);
            if (odd) begin
                radicand = 2 * radicand;
            end
            tbl[k] = 10'(isqrt(radicand) - 11'd1024);
        end
        return tbl;
    endfunction

    localparam logic [63:0][9:0] EVEN_ROOT = build_table(1'b0);
    localparam logic [63:0][9:0] ODD_ROOT  = build_table(1'b1);

    logic [4:0] e;
    logic [5:0] k;
    logic [5:0] exp_sum;
    fp16_u      res;

    assign e       = value_i.fields.exp;
    assign k       = value_i.fields.mant[9:4];
    assign exp_sum = {1'b0, e} + 6'd15;

    always_comb begin
        res.raw = '0;
        if (!value_i.fields.sign && e != 5'd0) begin
            res.fields.exp  = exp_sum[5:1];
            // Odd biased exponent means even unbiased exponent
            res.fields.mant = e[0] ? EVEN_ROOT[k] : ODD_ROOT[k];
        end
    end

    assign root_o = res;

endmodule

`default_nettype wire

// File: design/fp16_mul.sv
`timescale 1ns/1ps
`default_nettype none

module fp16_mul (
    input  norm_pkg::fp16_u a_i,
    input  norm_pkg::fp16_u b_i,
    output norm_pkg::fp16_u product_o
);
    import norm_pkg::*;

    logic [10:0]       sig_a;
    logic [10:0]       sig_b;
    logic [21:0]       sig_prod;
    logic              norm;
    logic [9:0]        mant;
    logic signed [6:0] exp_sum;
    logic              sign;
    logic              zero_in;
    fp16_u             res;

    ////////////////////////////////////////////////////////////
    // Significand product
    ////////////////////////////////////////////////////////////

    assign sig_a    = {1'b1, a_i.fields.mant};
    assign sig_b    = {1'b1, b_i.fields.mant};
    assign sig_prod = sig_a * sig_b;

    // Product in [1,4), at most one bit of shift
    assign norm = sig_prod[21];
    assign mant = norm ? sig_prod[20:11] : sig_prod[19:10];

    assign exp_sum = $signed({2'b00, a_i.fields.exp})
                   + $signed({2'b00, b_i.fields.exp})
                   + $signed({6'd0, norm})
                   - 7'sd15;

    assign sign    = a_i.fields.sign ^ b_i.fields.sign;
    assign zero_in = (a_i.fields.exp == 5'd0) || (b_i.fields.exp == 5'd0);

    ////////////////////////////////////////////////////////////
    // Flush and saturate
    ////////////////////////////////////////////////////////////

    always_comb begin
        res.fields.sign = sign;
        if (zero_in || exp_sum < 7'sd1) begin
            res.fields.exp  = '0;
            res.fields.mant = '0;
        end else if (exp_sum > 7'sd30) begin
            res.fields.exp  = FP16_MAX[14:10];
            res.fields.mant = FP16_MAX[9:0];
        end else begin
            res.fields.exp  = exp_sum[4:0];
            res.fields.mant = mant;
        end
    end

    assign product_o = res;

endmodule

`default_nettype wire

// File: design/norm_lane.sv
`timescale 1ns/1ps
`default_nettype none

module norm_lane #(
    parameter int N_POINTS = 4096
) (
    input  logic            CLK_i,
    input  logic            RST_i,
    stage_ctrl_if.lane      ctrl,
    input  norm_pkg::fp16_u operand_i,
    input  norm_pkg::fp16_u scale_i,
    input  norm_pkg::fp16_u norm_i,
    input  logic [15:0]     pos_i,
    output logic [15:0]     result1_o,
    output logic [15:0]     result2_o
);
    import norm_pkg::*;

    localparam logic [15:0] NO_CENTER = 16'(N_POINTS);

    fp16_u       root;
    fp16_u       scale_norm;
    fp16_u       recip_in;
    fp16_u       recip;
    fp16_u       q;
    fp16_u       best;
    logic [15:0] best_id;
    fp16_u       best_upd;
    logic [15:0] id_upd;
    logic        above;
    logic [15:0] r1_d;
    logic [15:0] r2_d;

    // Sign-magnitude a < b, both zeros equal
    function automatic logic fp_lt(input fp16_u a, input fp16_u b);
        logic lt;
        if (a.raw[14:0] == '0 && b.raw[14:0] == '0) begin
            lt = 1'b0;
        end else if (a.fields.sign != b.fields.sign) begin
            lt = a.fields.sign;
        end else if (!a.fields.sign) begin
            lt = a.raw[14:0] < b.raw[14:0];
        end else begin
            lt = a.raw[14:0] > b.raw[14:0];
        end
        return lt;
    endfunction

    ////////////////////////////////////////////////////////////
    // Arithmetic
    ////////////////////////////////////////////////////////////

    fp16_sqrt_rom u_sqrt (.value_i(operand_i), .root_o(root));

    fp16_mul u_scale_mul (.a_i(scale_i), .b_i(norm_i), .product_o(scale_norm));

    // Cosine divides by scale times norm
    assign recip_in = (ctrl.stage == STAGE_COS) ? scale_norm : scale_i;

    fp16_recip_rom u_recip (.value_i(recip_in), .recip_o(recip));

    fp16_mul u_div_mul (.a_i(operand_i), .b_i(recip), .product_o(q));

    ////////////////////////////////////////////////////////////
    // Running argmax
    ////////////////////////////////////////////////////////////

    always_comb begin
        best_upd = best;
        id_upd   = best_id;
        if (ctrl.stage_start || fp_lt(best, q)) begin
            best_upd = q;
            id_upd   = pos_i;
        end
    end

    // Argmax registers move only in the cosine stage
    always_ff @(posedge CLK_i) begin
        if (ctrl.advance && ctrl.stage == STAGE_COS) begin
            best    <= best_upd;
            best_id <= id_upd;
        end
    end

    assign above = fp_lt(fp16_u'(FP16_SIM_THRESH), best);

    // Output select
    always_comb begin
        r1_d = q.raw;
        r2_d = '0;
        if (!ctrl.done) begin
            case (ctrl.stage)
                STAGE_SQRT: r1_d = root.raw;
                STAGE_COS: begin
                    r1_d = root.raw;
                    r2_d = best_upd.raw;
                end
                STAGE_ASSIGN: begin
                    r1_d = above ? best_id : NO_CENTER;
                    r2_d = above ? best.raw : FP16_ONE;
                end
                default: r1_d = q.raw;
            endcase
        end
    end

    always_ff @(posedge CLK_i) begin
        if (RST_i) begin
            result1_o <= '0;
            result2_o <= '0;
        end else if (ctrl.advance) begin
            result1_o <= r1_d;
            result2_o <= r2_d;
        end
    end

endmodule

`default_nettype wire

// File: design/norm_stage_top.sv
`timescale 1ns/1ps
`default_nettype none

module norm_stage_top #(
    parameter int LANES    = 2,
    parameter int STEP_W   = 16,
    parameter int N_POINTS = 4096
) (
    input  logic                         CLK_i,
    input  logic                         RST_i,
    input  logic                         stall_i,
    input  logic [6:0][STEP_W-1:0]       boundary_i,
    input  logic [LANES-1:0][15:0]       operand_i,
    input  logic [LANES-1:0][15:0]       scale_i,
    input  logic [LANES-1:0][15:0]       norm_i,
    input  logic [LANES-1:0][15:0]       pos_i,
    output logic [LANES-1:0][15:0]       result1_o,
    output logic [LANES-1:0][15:0]       result2_o,
    output logic [norm_pkg::STAGE_W-1:0] stage_o,
    output logic                         mode_o,
    output logic                         finished_o
);

    stage_ctrl_if ctrl ();

    ////////////////////////////////////////////////////////////
    // Control
    ////////////////////////////////////////////////////////////

    stage_sequencer #(
        .STEP_W(STEP_W)
    ) u_seq (
        .CLK_i      (CLK_i),
        .RST_i      (RST_i),
        .stall_i    (stall_i),
        .boundary_i (boundary_i),
        .ctrl       (ctrl.seq),
        .mode_o     (mode_o),
        .finished_o (finished_o),
        .stage_o    (stage_o)
    );

    ////////////////////////////////////////////////////////////
    // Lanes
    ////////////////////////////////////////////////////////////

    for (genvar i = 0; i < LANES; i++) begin : g_lane
        norm_lane #(
            .N_POINTS(N_POINTS)
        ) u_lane (
            .CLK_i     (CLK_i),
            .RST_i     (RST_i),
            .ctrl      (ctrl.lane),
            .operand_i (operand_i[i]),
            .scale_i   (scale_i[i]),
            .norm_i    (norm_i[i]),
            .pos_i     (pos_i[i]),
            .result1_o (result1_o[i]),
            .result2_o (result2_o[i])
        );
    end

endmodule

`default_nettype wire

// File: bench/norm_stage_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module norm_stage_assertions #(
    parameter int LANES = 2
) (
    input  logic                         CLK_i,
    input  logic                         RST_i,
    input  logic                         stall_i,
    input  logic                         stage_start_i,
    input  logic [norm_pkg::STAGE_W-1:0] stage_i,
    input  logic                         finished_i,
    input  logic [LANES-1:0][15:0]       result1_i,
    input  logic [LANES-1:0][15:0]       result2_i
);
    import norm_pkg::*;

    // Number of assertion failures so far
    int fail_count = 0;

    ////////////////////////////////////////////////////////////
    // Stage progression
    ////////////////////////////////////////////////////////////

    a_stage_monotonic: assert property (@(posedge CLK_i) disable iff (RST_i)
        !$past(RST_i) |-> stage_i >= $past(stage_i))
        else begin
            fail_count++;
            $error("stage decreased without reset");
        end

    a_finished_flag: assert property (@(posedge CLK_i) disable iff (RST_i)
        finished_i == (stage_i == STAGE_DONE))
        else begin
            fail_count++;
            $error("finished flag does not match the last stage");
        end

    // A second pulse is only legal when the stage moved again
    a_start_pulse: assert property (@(posedge CLK_i) disable iff (RST_i)
        stage_start_i |=> !stage_start_i || (stage_i != $past(stage_i)))
        else begin
            fail_count++;
            $error("stage start pulse held for two cycles");
        end

    ////////////////////////////////////////////////////////////
    // Stall
    ////////////////////////////////////////////////////////////

    a_stall_freeze: assert property (@(posedge CLK_i) disable iff (RST_i)
        $past(stall_i) && !$past(RST_i) |->
            $stable(stage_i) && $stable(result1_i) && $stable(result2_i))
        else begin
            fail_count++;
            $error("stage or results moved during a stall");
        end

endmodule

`default_nettype wire

// File: bench/norm_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module norm_stage_tb;
    import norm_pkg::*;

    localparam int LANES    = 2;
    localparam int STEP_W   = 16;
    localparam int N_POINTS = 4096;
    localparam int TIMEOUT  = 200;

    logic                   CLK_i;
    logic                   RST_i;
    logic                   stall_i;
    logic [6:0][STEP_W-1:0] boundary_i;
    logic [LANES-1:0][15:0] operand_i;
    logic [LANES-1:0][15:0] scale_i;
    logic [LANES-1:0][15:0] norm_i;
    logic [LANES-1:0][15:0] pos_i;
    logic [LANES-1:0][15:0] result1_o;
    logic [LANES-1:0][15:0] result2_o;
    logic [STAGE_W-1:0]     stage_o;
    logic                   mode_o;
    logic                   finished_o;
    logic [15:0]            lfsr_state;

    norm_stage_top #(
        .LANES    (LANES),
        .STEP_W   (STEP_W),
        .N_POINTS (N_POINTS)
    ) UUT (
        .CLK_i      (CLK_i),
        .RST_i      (RST_i),
        .stall_i    (stall_i),
        .boundary_i (boundary_i),
        .operand_i  (operand_i),
        .scale_i    (scale_i),
        .norm_i     (norm_i),
        .pos_i      (pos_i),
        .result1_o  (result1_o),
        .result2_o  (result2_o),
        .stage_o    (stage_o),
        .mode_o     (mode_o),
        .finished_o (finished_o)
    );

    bind norm_stage_top norm_stage_assertions #(
        .LANES(LANES)
    ) u_assert (
        .CLK_i         (CLK_i),
        .RST_i         (RST_i),
        .stall_i       (stall_i),
        .stage_start_i (ctrl.stage_start),
        .stage_i       (stage_o),
        .finished_i    (finished_o),
        .result1_i     (result1_o),
        .result2_i     (result2_o)
    );

    initial CLK_i = 1'b0;
    always #20 CLK_i = ~CLK_i;

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    function automatic logic [15:0] ref_mul(input logic [15:0] a, input logic [15:0] b);
        int          prod;
        int          e;
        logic        s;
        logic [21:0] p;
        s    = a[15] ^ b[15];
        prod = (1024 + int'(a[9:0])) * (1024 + int'(b[9:0]));
        p    = 22'(prod);
        e    = int'(a[14:10]) + int'(b[14:10]) - 15 + int'(p[21]);
        if (a[14:10] == 5'd0 || b[14:10] == 5'd0 || e < 1) begin
            return {s, 15'd0};
        end
        if (e > 30) begin
            return {s, 15'h7BFF};
        end
        return {s, 5'(e), p[21] ? p[20:11] : p[19:10]};
    endfunction

    function automatic logic [15:0] ref_recip(input logic [15:0] x);
        int e;
        int k;
        int ne;
        int mant;
        e = int'(x[14:10]);
        k = int'(x[9:4]);
        if (e == 0) begin
            return {x[15], 15'h7BFF};
        end
        ne   = (k == 0) ? 30 - e : 29 - e;
        mant = (k == 0) ? 0 : 131072 / (64 + k) - 1024;
        if (e >= 30 || ne < 1) begin
            return {x[15], 15'd0};
        end
        return {x[15], 5'(ne), 10'(mant)};
    endfunction

    function automatic logic [15:0] ref_sqrt(input logic [15:0] x);
        int u;
        int ne;
        int r;
        int s;
        if (x[15] || x[14:10] == 5'd0) begin
            return 16'd0;
        end
        u = int'(x[14:10]) - 15;
        r = 16384 * (64 + int'(x[9:4]));
        if (u % 2 == 0) begin
            ne = 15 + u / 2;
        end else begin
            ne = 15 + (u - 1) / 2;
            r  = 2 * r;
        end
        s = 1024;
        while ((s + 1) * (s + 1) <= r) begin
            s++;
        end
        return {1'b0, 5'(ne), 10'(s - 1024)};
    endfunction

    // Sign-magnitude order, the two zeros equal
    function automatic logic ref_lt(input logic [15:0] a, input logic [15:0] b);
        if (a[14:0] == 15'd0 && b[14:0] == 15'd0) begin
            return 1'b0;
        end
        if (a[15] != b[15]) begin
            return a[15];
        end
        return a[15] ? (a[14:0] > b[14:0]) : (a[14:0] < b[14:0]);
    endfunction

    ////////////////////////////////////////////////////////////
    // Random data
    ////////////////////////////////////////////////////////////

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [15:0] take_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[14:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // Exponent drawn from lo .. lo+span-1
    function automatic logic [15:0] rand_fp16(input int lo, input int span);
        logic [15:0] s;
        logic [15:0] e;
        logic [15:0] m;
        s = take_bits(1);
        e = take_bits(4);
        m = take_bits(10);
        return {s[0], 5'(lo + int'(e) % span), m[9:0]};
    endfunction

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    task automatic stop_with_failure();
        $display("TEST FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input logic [15:0] got, input logic [15:0] expected,
                               input string what);
        if (got !== expected) begin
            $display("** Error at %0t ns: %s got %h, expected %h", $time, what, got, expected);
            stop_with_failure();
        end
    endtask

    task automatic next_cycle();
        @(posedge CLK_i);
        #2;
    endtask

    task automatic apply_reset(input logic [6:0][STEP_W-1:0] bounds);
        boundary_i = bounds;
        stall_i    = 1'b0;
        RST_i      = 1'b1;
        repeat (4) next_cycle();
        RST_i = 1'b0;
    endtask

    task automatic wait_stage(input logic [STAGE_W-1:0] target);
        int cycles;
        cycles = 0;
        while (stage_o != target) begin
            if (cycles == TIMEOUT) begin
                $display("Timed out waiting for stage %0d", target);
                stop_with_failure();
            end
            next_cycle();
            cycles++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////

    task automatic test_reset();
        apply_reset({7{16'hFFFF}});
        for (int l = 0; l < LANES; l++) begin
            check_value(result1_o[l], 16'd0, "result1 after reset");
            check_value(result2_o[l], 16'd0, "result2 after reset");
        end
        check_value(16'(stage_o), 16'd0, "stage after reset");
        check_value(16'(finished_o), 16'd0, "finished after reset");
        check_value(16'(mode_o), 16'd1, "mode after reset");
    endtask

    task automatic test_scale_divide();
        logic [LANES-1:0][15:0] expect_q;
        apply_reset({7{16'hFFFF}});
        for (int n = 0; n < 50; n++) begin
            for (int l = 0; l < LANES; l++) begin
                operand_i[l] = rand_fp16(10, 11);
                scale_i[l]   = rand_fp16(10, 11);
                expect_q[l]  = ref_mul(operand_i[l], ref_recip(scale_i[l]));
            end
            next_cycle();
            check_value(16'(stage_o), 16'd0, "stage with unreachable boundaries");
            for (int l = 0; l < LANES; l++) begin
                check_value(result1_o[l], expect_q[l], "quotient");
                check_value(result2_o[l], 16'd0, "result2 in divide stage");
            end
        end
    endtask

    task automatic test_stage_walk();
        logic [6:0][STEP_W-1:0] bounds;
        logic [LANES-1:0][15:0] held1;
        logic [LANES-1:0][15:0] held2;
        int                     tb_step;
        int                     tb_stage;
        int                     cycles;
        logic                   stalled;
        for (int i = 0; i < 7; i++) begin
            bounds[i] = 16'(3 * (i + 1));
        end
        apply_reset(bounds);
        tb_step  = 0;
        tb_stage = 0;
        cycles   = 0;
        stalled  = 1'b0;
        while (tb_stage != 7) begin
            if (cycles == TIMEOUT) begin
                $display("Timed out walking the stages");
                stop_with_failure();
            end
            // One stall burst in the middle of the walk
            if (tb_stage == 3 && !stalled) begin
                stall_i = 1'b1;
                held1   = result1_o;
                held2   = result2_o;
                repeat (5) begin
                    for (int l = 0; l < LANES; l++) begin
                        operand_i[l] = rand_fp16(10, 11);
                    end
                    next_cycle();
                    check_value(16'(stage_o), 16'd3, "stage during stall");
                    for (int l = 0; l < LANES; l++) begin
                        check_value(result1_o[l], held1[l], "result1 during stall");
                        check_value(result2_o[l], held2[l], "result2 during stall");
                    end
                end
                stall_i = 1'b0;
                stalled = 1'b1;
            end
            for (int l = 0; l < LANES; l++) begin
                operand_i[l] = rand_fp16(10, 11);
                scale_i[l]   = rand_fp16(10, 11);
            end
            next_cycle();
            tb_stage = 0;
            for (int i = 0; i < 7; i++) begin
                if (int'(bounds[i]) < tb_step) begin
                    tb_stage++;
                end
            end
            tb_step++;
            check_value(16'(stage_o), 16'(tb_stage), "stage");
            check_value(16'(mode_o), 16'(tb_stage != 1), "mode");
            check_value(16'(finished_o), 16'(tb_stage == 7), "finished");
            cycles++;
        end
    endtask

    task automatic test_sqrt();
        logic [LANES-1:0][15:0] expect_root;
        apply_reset({16'd170, 16'd160, 16'd150, 16'd7, 16'd5, 16'd3, 16'd1});
        wait_stage(STAGE_SQRT);
        for (int n = 0; n < 40; n++) begin
            for (int l = 0; l < LANES; l++) begin
                operand_i[l]   = rand_fp16(10, 11);
                expect_root[l] = ref_sqrt(operand_i[l]);
            end
            next_cycle();
            for (int l = 0; l < LANES; l++) begin
                check_value(result1_o[l], expect_root[l], "square root");
                check_value(result2_o[l], 16'd0, "result2 in root stage");
            end
        end
    endtask

    task automatic test_argmax_assign(input logic high);
        logic [LANES-1:0][15:0] best;
        logic [LANES-1:0][15:0] best_id;
        logic [LANES-1:0][15:0] expect_root;
        logic [15:0]            q;
        logic                   above;
        apply_reset({16'd200, 16'd30, 16'd9, 16'd7, 16'd5, 16'd3, 16'd1});
        wait_stage(STAGE_COS);
        for (int n = 0; n < 12; n++) begin
            check_value(16'(stage_o), 16'(STAGE_COS), "stage while feeding cosines");
            for (int l = 0; l < LANES; l++) begin
                operand_i[l] = rand_fp16(high ? 14 : 13, 1);
                scale_i[l]   = rand_fp16(15, 1);
                norm_i[l]    = rand_fp16(15, 1);
                pos_i[l]     = 16'(n + 100 * l);
                // Near-perfect match pushes the best above the threshold
                if (high && n == 5) begin
                    operand_i[l] = 16'h3BF0;
                    scale_i[l]   = 16'h3C00;
                    norm_i[l]    = 16'h3C00;
                end
                q = ref_mul(operand_i[l], ref_recip(ref_mul(scale_i[l], norm_i[l])));
                if (n == 0 || ref_lt(best[l], q)) begin
                    best[l]    = q;
                    best_id[l] = pos_i[l];
                end
                expect_root[l] = ref_sqrt(operand_i[l]);
            end
            next_cycle();
            for (int l = 0; l < LANES; l++) begin
                check_value(result1_o[l], expect_root[l], "root in cosine stage");
                check_value(result2_o[l], best[l], "running best");
            end
        end
        wait_stage(STAGE_ASSIGN);
        next_cycle();
        for (int l = 0; l < LANES; l++) begin
            above = ref_lt(16'h3BD7, best[l]);
            check_value(result1_o[l], above ? best_id[l] : 16'(N_POINTS), "assigned id");
            check_value(result2_o[l], above ? best[l] : 16'h3C00, "assigned similarity");
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    always @(negedge CLK_i) begin
        if (UUT.u_assert.fail_count != 0) begin
            $display("A bound assertion failed");
            stop_with_failure();
        end
    end

    initial begin
        lfsr_state = 16'd7398;
        RST_i      = 1'b1;
        stall_i    = 1'b0;
        boundary_i = '1;
        operand_i  = '0;
        scale_i    = '0;
        norm_i     = '0;
        pos_i      = '0;

        test_reset();
        test_scale_divide();
        test_stage_walk();
        test_sqrt();
        test_argmax_assign(1'b1);
        test_argmax_assign(1'b0);

        if (UUT.u_assert.fail_count == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("A bound assertion failed");
            stop_with_failure();
        end
    end

endmodule

`default_nettype wire

// File: filelist.f
design/norm_pkg.sv
design/stage_ctrl_if.sv
design/stage_sequencer.sv
design/fp16_recip_rom.sv
design/fp16_sqrt_rom.sv
design/fp16_mul.sv
design/norm_lane.sv
design/norm_stage_top.sv
bench/norm_stage_assertions.sv
bench/norm_stage_tb.sv

// File: Makefile
# Verilator build and run for the fp16 normalization stage

VERILATOR ?= verilator
TOP       ?= norm_stage_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= TEST PASS

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
